// ==== verilog/eth_gtp_bridge_pkg.sv ====
`default_nettype none

package eth_gtp_bridge_pkg;

  // -------------------- stream widths
  localparam int BYTE_W = 8;                    // mac rx byte
  localparam int WORD_W = 16;                   // transmitter word
  localparam int KEEP_W = 2;                    // one keep bit per byte

  // -------------------- config channel
  localparam int CFG_ADDR_W = 12;               // mac register space
  localparam int CFG_DATA_W = 32;
  localparam int CFG_RESP_W = 2;
  localparam logic [CFG_RESP_W-1:0] RESP_OKAY = 2'b00;

  localparam int FIFO_DEPTH = 16;               // rx elastic buffer
  localparam int FIFO_PTR_W = 4;                // log2 of depth

  localparam int HOLD_CYCLES = 16;              // settle time after reset
  localparam int HOLD_CNT_W = 5;

  localparam int NUM_CFG_WRITES = 3;
  localparam int CFG_IDX_W = 2;                 // write list index

  // mac register map
  localparam logic [CFG_ADDR_W-1:0] REG_SPEED_ADDR = 12'h194;  // speed config
  localparam logic [CFG_ADDR_W-1:0] REG_RX_CFG_ADDR = 12'h404; // receiver config word 1
  localparam logic [CFG_ADDR_W-1:0] REG_TX_CFG_ADDR = 12'h408; // transmitter config
  localparam logic [CFG_DATA_W-1:0] SPEED_1G_VAL = 32'h8000_0000;  // bits 31:30 = 10
  localparam logic [CFG_DATA_W-1:0] RX_ENABLE_VAL = 32'h1000_0000; // bit 28
  localparam logic [CFG_DATA_W-1:0] TX_ENABLE_VAL = 32'h1000_0000; // bit 28

  typedef struct packed {
    logic [BYTE_W-1:0] data;                    // received byte
    logic              last;                    // frame end
  } rx_byte_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;                    // first byte in [15:8]
    logic [KEEP_W-1:0] keep;                    // 2'b10 = high byte only
    logic              last;
  } tx_word_t;

  typedef struct packed {
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] data;
  } cfg_wr_t;

  // entry 0 goes out first: speed, then rx, then tx
  localparam cfg_wr_t [NUM_CFG_WRITES-1:0] CFG_WRITE_LIST = {
    cfg_wr_t'{addr: REG_TX_CFG_ADDR, data: TX_ENABLE_VAL},
    cfg_wr_t'{addr: REG_RX_CFG_ADDR, data: RX_ENABLE_VAL},
    cfg_wr_t'{addr: REG_SPEED_ADDR, data: SPEED_1G_VAL}
  };

endpackage

`default_nettype wire

// ==== verilog/reset_hold_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_hold_timer (
  input  logic gtp_usr_clk,
  input  logic reset_i,           // sync, active high
  input  logic hold_start_i,      // load and start counting
  output logic hold_done_o        // single-cycle pulse at zero
);

  import eth_gtp_bridge_pkg::*;

  logic [HOLD_CNT_W-1:0] cnt_q;   // cycles left
  logic                  running_q;

  // zero reached while running, HOLD_CYCLES cycles after start
  assign hold_done_o = running_q && (cnt_q == '0);

  always_ff @(posedge gtp_usr_clk)
  begin
    if (reset_i)
    begin
      cnt_q     <= '0;
      running_q <= 1'b0;
    end
    else if (hold_start_i)
    begin
      cnt_q     <= HOLD_CNT_W'(HOLD_CYCLES - 1);  // done shows on the last count
      running_q <= 1'b1;
    end
    else if (hold_done_o)
      running_q <= 1'b0;                          // one pulse only
    else if (running_q)
      cnt_q <= cnt_q - 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/mac_config_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_config_fsm (
  input  logic                                      gtp_usr_clk,
  input  logic                                      reset_i,
  output logic                                      hold_start_o,     // to hold timer
  input  logic                                      hold_done_i,
  output eth_gtp_bridge_pkg::cfg_wr_t               cfg_wr_o,         // addr + data
  output logic                                      cfg_wr_valid_o,
  input  logic                                      cfg_wr_ready_i,
  input  logic [eth_gtp_bridge_pkg::CFG_RESP_W-1:0] cfg_resp_i,
  input  logic                                      cfg_resp_valid_i,
  output logic                                      cfg_resp_ready_o,
  output logic                                      datapath_en_o,    // release tx words
  output logic                                      config_done_o,
  output logic                                      config_error_o    // sticky
);

  import eth_gtp_bridge_pkg::*;

  typedef enum logic [1:0] {
    ST_HOLD  = 2'd0,              // waiting out the reset hold
    ST_WRITE = 2'd1,              // request on the channel
    ST_RESP  = 2'd2,              // waiting for write response
    ST_DONE  = 2'd3               // list finished
  } cfg_state_t;

  cfg_state_t           state_q;
  logic [CFG_IDX_W-1:0] idx_q;          // current write list entry
  logic                 hold_issued_q;  // timer already started
  logic                 error_q;
  logic                 wr_fire;
  logic                 resp_fire;
  logic                 last_entry;

  // -------------------- channel outputs
  assign cfg_wr_o         = CFG_WRITE_LIST[idx_q];
  assign cfg_wr_valid_o   = (state_q == ST_WRITE);
  assign cfg_resp_ready_o = (state_q == ST_RESP);
  assign wr_fire          = cfg_wr_valid_o && cfg_wr_ready_i;
  assign resp_fire        = cfg_resp_ready_o && cfg_resp_valid_i;
  assign last_entry       = (idx_q == CFG_IDX_W'(NUM_CFG_WRITES - 1));

  // kick the timer once, first cycle out of reset
  assign hold_start_o = (state_q == ST_HOLD) && !hold_issued_q;

  assign config_done_o  = (state_q == ST_DONE);
  assign datapath_en_o  = (state_q == ST_DONE);  // same as done
  assign config_error_o = error_q;

  // -------------------- sequencer
  always_ff @(posedge gtp_usr_clk)
  begin
    if (reset_i)
    begin
      state_q       <= ST_HOLD;
      idx_q         <= '0;
      hold_issued_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_HOLD:
        begin
          if (hold_start_o)
            hold_issued_q <= 1'b1;
          if (hold_done_i)
            state_q <= ST_WRITE;               // first request next cycle
        end
        ST_WRITE:
        begin
          if (wr_fire)
            state_q <= ST_RESP;
        end
        ST_RESP:
        begin
          if (resp_fire)
          begin
            if (last_entry)
              state_q <= ST_DONE;
            else
            begin
              idx_q   <= idx_q + 1'b1;         // next list entry
              state_q <= ST_WRITE;
            end
          end
        end
        default: state_q <= ST_DONE;          // stays until reset
      endcase
    end
  end

  // -------------------- error flag
  always_ff @(posedge gtp_usr_clk)
  begin
    if (reset_i)
      error_q <= 1'b0;
    else if (resp_fire && (cfg_resp_i != RESP_OKAY))
      error_q <= 1'b1;                        // slverr / decerr
  end

endmodule

`default_nettype wire

// ==== verilog/rx_byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_byte_fifo (
  input  logic                           gtp_usr_clk,
  input  logic                           reset_i,
  input  eth_gtp_bridge_pkg::rx_byte_t   s_byte_i,   // from mac rx
  input  logic                           s_valid_i,
  output logic                           s_ready_o,  // low when full
  output eth_gtp_bridge_pkg::rx_byte_t   m_byte_o,   // to packer
  output logic                           m_valid_o,
  input  logic                           m_ready_i
);

  import eth_gtp_bridge_pkg::*;

  rx_byte_t              mem_q [FIFO_DEPTH];  // byte + last
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;             // 0 .. FIFO_DEPTH
  logic                  wr_en;
  logic                  rd_en;

  // -------------------- flags from registered count
  assign s_ready_o = (count_q != (FIFO_PTR_W + 1)'(FIFO_DEPTH));
  assign m_valid_o = (count_q != '0);
  assign m_byte_o  = mem_q[rd_ptr_q];          // head, first-word fall-through

  assign wr_en = s_valid_i && s_ready_o;
  assign rd_en = m_valid_o && m_ready_i;

  // storage
  always_ff @(posedge gtp_usr_clk)
  begin
    if (wr_en)
      mem_q[wr_ptr_q] <= s_byte_i;
  end

  // -------------------- pointers, count
  always_ff @(posedge gtp_usr_clk)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;           // wraps at depth
      if (rd_en)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;           // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/byte_to_word_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_to_word_packer (
  input  logic                           gtp_usr_clk,
  input  logic                           reset_i,
  input  logic                           enable_i,   // config done
  input  eth_gtp_bridge_pkg::rx_byte_t   s_byte_i,
  input  logic                           s_valid_i,
  output logic                           s_ready_o,
  output eth_gtp_bridge_pkg::tx_word_t   m_word_o,   // to transmitter
  output logic                           m_valid_o,
  input  logic                           m_ready_i
);

  import eth_gtp_bridge_pkg::*;

  rx_byte_t stage_q;        // even byte waiting for its pair
  logic     stage_vld_q;
  tx_word_t out_q;          // word on offer
  logic     out_vld_q;
  tx_word_t word_d;
  logic     out_fire;
  logic     out_free;       // output slot empty or leaving
  logic     s_fire;
  logic     load_out;
  logic     load_stage;

  assign m_word_o  = out_q;
  assign m_valid_o = out_vld_q && enable_i;    // held back until config done
  assign out_fire  = m_valid_o && m_ready_i;
  assign out_free  = !out_vld_q || out_fire;

  // stage empty takes anything, a paired byte needs the output slot
  assign s_ready_o = !stage_vld_q || (out_free && !stage_q.last);
  assign s_fire    = s_valid_i && s_ready_o;

  // -------------------- word assembly
  always_comb
  begin
    load_out   = 1'b0;
    load_stage = 1'b0;
    word_d     = '0;
    if (stage_vld_q && stage_q.last && out_free)
    begin
      load_out    = 1'b1;                      // flush lone frame end
      word_d.data = {stage_q.data, {BYTE_W{1'b0}}};
      word_d.keep = 2'b10;
      word_d.last = 1'b1;
    end
    else if (s_fire && stage_vld_q)
    begin
      load_out    = 1'b1;                      // odd byte completes pair
      word_d.data = {stage_q.data, s_byte_i.data};  // first byte high
      word_d.keep = 2'b11;
      word_d.last = s_byte_i.last;
    end
    else if (s_fire && s_byte_i.last && out_free)
    begin
      load_out    = 1'b1;                      // odd-length frame, straight out
      word_d.data = {s_byte_i.data, {BYTE_W{1'b0}}};
      word_d.keep = 2'b10;
      word_d.last = 1'b1;
    end
    else if (s_fire)
      load_stage = 1'b1;                       // even byte, or last under stall
  end

  // -------------------- control
  always_ff @(posedge gtp_usr_clk)
  begin
    if (reset_i)
    begin
      stage_vld_q <= 1'b0;
      out_vld_q   <= 1'b0;
    end
    else
    begin
      if (load_stage)
        stage_vld_q <= 1'b1;
      else if (load_out)
        stage_vld_q <= 1'b0;                   // stage consumed
      if (load_out)
        out_vld_q <= 1'b1;
      else if (out_fire)
        out_vld_q <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge gtp_usr_clk)
  begin
    if (load_stage)
      stage_q <= s_byte_i;
    if (load_out)
      out_q <= word_d;
  end

endmodule

`default_nettype wire

// ==== verilog/eth_gtp_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_gtp_bridge_top (
  input  logic                                      gtp_usr_clk,
  input  logic                                      reset_i,
  // -------------------- rx byte stream
  input  eth_gtp_bridge_pkg::rx_byte_t              rx_byte_i,
  input  logic                                      rx_valid_i,
  output logic                                      rx_ready_o,
  // -------------------- tx word stream
  output eth_gtp_bridge_pkg::tx_word_t              tx_word_o,
  output logic                                      tx_valid_o,
  input  logic                                      tx_ready_i,
  // -------------------- mac config channel
  output eth_gtp_bridge_pkg::cfg_wr_t               cfg_wr_o,
  output logic                                      cfg_wr_valid_o,
  input  logic                                      cfg_wr_ready_i,
  input  logic [eth_gtp_bridge_pkg::CFG_RESP_W-1:0] cfg_resp_i,
  input  logic                                      cfg_resp_valid_i,
  output logic                                      cfg_resp_ready_o,
  // status
  output logic                                      config_done_o,
  output logic                                      config_error_o
);

  import eth_gtp_bridge_pkg::*;

  logic     hold_start;      // fsm -> timer
  logic     hold_done;       // timer -> fsm
  logic     datapath_en;     // fsm -> packer
  rx_byte_t fifo_byte;       // fifo head
  logic     fifo_valid;
  logic     fifo_ready;

  reset_hold_timer u_hold_timer (
    .gtp_usr_clk      (gtp_usr_clk),
    .reset_i          (reset_i),
    .hold_start_i     (hold_start),
    .hold_done_o      (hold_done)
  );

  mac_config_fsm u_cfg_fsm (
    .gtp_usr_clk      (gtp_usr_clk),
    .reset_i          (reset_i),
    .hold_start_o     (hold_start),
    .hold_done_i      (hold_done),
    .cfg_wr_o         (cfg_wr_o),
    .cfg_wr_valid_o   (cfg_wr_valid_o),
    .cfg_wr_ready_i   (cfg_wr_ready_i),
    .cfg_resp_i       (cfg_resp_i),
    .cfg_resp_valid_i (cfg_resp_valid_i),
    .cfg_resp_ready_o (cfg_resp_ready_o),
    .datapath_en_o    (datapath_en),
    .config_done_o    (config_done_o),
    .config_error_o   (config_error_o)
  );

  rx_byte_fifo u_rx_fifo (
    .gtp_usr_clk      (gtp_usr_clk),
    .reset_i          (reset_i),
    .s_byte_i         (rx_byte_i),
    .s_valid_i        (rx_valid_i),
    .s_ready_o        (rx_ready_o),   // drops when full
    .m_byte_o         (fifo_byte),
    .m_valid_o        (fifo_valid),
    .m_ready_i        (fifo_ready)
  );

  byte_to_word_packer u_packer (
    .gtp_usr_clk      (gtp_usr_clk),
    .reset_i          (reset_i),
    .enable_i         (datapath_en),
    .s_byte_i         (fifo_byte),
    .s_valid_i        (fifo_valid),
    .s_ready_o        (fifo_ready),
    .m_word_o         (tx_word_o),
    .m_valid_o        (tx_valid_o),
    .m_ready_i        (tx_ready_i)
  );

endmodule

`default_nettype wire

// ==== verification/tb_eth_gtp_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eth_gtp_bridge;

  import eth_gtp_bridge_pkg::*;

  localparam int TIMEOUT_CYC = 1000;                  // per wait loop
  localparam int MAX_BYTES = 32;                      // per run
  localparam int MAX_WORDS = 16;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1

  logic                  gtp_usr_clk;
  logic                  reset_i;
  rx_byte_t              rx_byte_i;
  logic                  rx_valid_i;
  logic                  rx_ready_o;
  tx_word_t              tx_word_o;
  logic                  tx_valid_o;
  logic                  tx_ready_i;
  cfg_wr_t               cfg_wr_o;
  logic                  cfg_wr_valid_o;
  logic                  cfg_wr_ready_i;
  logic [CFG_RESP_W-1:0] cfg_resp_i;
  logic                  cfg_resp_valid_i;
  logic                  cfg_resp_ready_o;
  logic                  config_done_o;
  logic                  config_error_o;

  // -------------------- pattern tables, index 0/1 = run
  logic [CFG_ADDR_W-1:0] exp_addr [2][NUM_CFG_WRITES];
  logic [CFG_DATA_W-1:0] exp_data [2][NUM_CFG_WRITES];
  logic [CFG_RESP_W-1:0] resp_code [2][NUM_CFG_WRITES];   // slave answer per write
  rx_byte_t              in_bytes [2][MAX_BYTES];
  tx_word_t              exp_words [2][MAX_WORDS];
  int                    cfg_n [2];
  int                    byte_n [2];
  int                    word_n [2];

  logic [31:0] lfsr_q;
  int          mismatch_cnt;
  int          other_cnt;
  logic        abort;               // a wait timed out
  logic        monitor_en;
  logic        saw_full;            // rx_ready_o seen low under valid
  int          stall_bytes;         // accepted since last word left
  logic        word_held;           // word offered but not taken
  tx_word_t    held_word;

  eth_gtp_bridge_top dut0 (
    .gtp_usr_clk      (gtp_usr_clk),
    .reset_i          (reset_i),
    .rx_byte_i        (rx_byte_i),
    .rx_valid_i       (rx_valid_i),
    .rx_ready_o       (rx_ready_o),
    .tx_word_o        (tx_word_o),
    .tx_valid_o       (tx_valid_o),
    .tx_ready_i       (tx_ready_i),
    .cfg_wr_o         (cfg_wr_o),
    .cfg_wr_valid_o   (cfg_wr_valid_o),
    .cfg_wr_ready_i   (cfg_wr_ready_i),
    .cfg_resp_i       (cfg_resp_i),
    .cfg_resp_valid_i (cfg_resp_valid_i),
    .cfg_resp_ready_o (cfg_resp_ready_o),
    .config_done_o    (config_done_o),
    .config_error_o   (config_error_o)
  );

  initial
  begin
    gtp_usr_clk = 1'b0;
    forever #5 gtp_usr_clk = ~gtp_usr_clk;   // 100 MHz
  end

  // -------------------- helpers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);   // galois, shift right
  endfunction

  function logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);             // one step per bit
    return lfsr_q[0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got 0x%0h expected 0x%0h at %0t ns", name, got, exp, $time);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("%s at %0t ns", what, $time);
    other_cnt++;
  endtask

  task automatic load_patterns();
    int          fd;
    int          r;
    int          nb;
    int          k;
    string       line;
    logic [31:0] kind;
    logic [31:0] run;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    for (r = 0; r < 2; r++)
    begin
      cfg_n[r]  = 0;
      byte_n[r] = 0;
      word_n[r] = 0;
    end
    fd = $fopen("verification/bridge_patterns.txt", "r");
    if (fd == 0)
    begin
      report_failure("pattern file verification/bridge_patterns.txt could not be opened");
      abort = 1'b1;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) == 0 || line[0] == "#")
          continue;                                      // column notes
        if ($sscanf(line, "%h %h %h %h %h", kind, run, f1, f2, f3) != 5)
          continue;                                      // blank line
        r = int'(run[0]);
        if (kind == 1 && cfg_n[r] < NUM_CFG_WRITES)
        begin
          exp_addr[r][cfg_n[r]]  = f1[CFG_ADDR_W-1:0];
          exp_data[r][cfg_n[r]]  = f2;
          resp_code[r][cfg_n[r]] = f3[CFG_RESP_W-1:0];
          cfg_n[r]++;
        end
        else if (kind == 2 && f1 >= 1 && f1 <= 4 && byte_n[r] + int'(f1) <= MAX_BYTES)
        begin
          nb = int'(f1);
          for (k = 0; k < nb; k++)
          begin
            in_bytes[r][byte_n[r]].data = f2[8*(nb-1-k) +: 8];   // first byte leftmost
            in_bytes[r][byte_n[r]].last = f3[0] && (k == nb - 1);
            byte_n[r]++;
          end
        end
        else if (kind == 3 && word_n[r] < MAX_WORDS)
        begin
          exp_words[r][word_n[r]] = {f1[WORD_W-1:0], f2[KEEP_W-1:0], f3[0]};
          word_n[r]++;
        end
        else
          report_failure("pattern file line not understood or table full");
      end
      $fclose(fd);
      if (cfg_n[0] != NUM_CFG_WRITES || cfg_n[1] != NUM_CFG_WRITES || word_n[0] == 0)
      begin
        report_failure("pattern file is missing configuration writes or words");
        abort = 1'b1;
      end
    end
  endtask

  task automatic apply_reset();
    @(negedge gtp_usr_clk);
    reset_i = 1'b1;
    repeat (2) @(negedge gtp_usr_clk);     // two rising edges in reset
    reset_i = 1'b0;
  endtask

  // -------------------- configuration slave
  task automatic serve_config(input int run);
    int   i;
    int   wait_cyc;
    int   delay;
    logic took;
    logic seen_valid;
    logic exp_err;
    exp_err    = 1'b0;
    seen_valid = 1'b0;
    for (i = 0; i < cfg_n[run] && !abort; i++)
    begin
      took     = 1'b0;
      wait_cyc = 0;
      while (!took && !abort)
      begin
        @(negedge gtp_usr_clk);
        cfg_resp_valid_i = 1'b0;
        cfg_wr_ready_i   = rand_bit();         // random request stall
        #1;
        if (i == 0 && cfg_wr_valid_o && !seen_valid)
        begin
          seen_valid = 1'b1;                   // hold timer length seen from outside
          check_value("cfg_wr_valid_o rise cycle", 64'(wait_cyc), 64'(HOLD_CYCLES));
        end
        if (config_done_o)
          report_failure("config_done_o high before the last write response");
        if (cfg_wr_valid_o && cfg_wr_ready_i)
        begin
          took = 1'b1;
          check_value("cfg_wr_o.addr", 64'(cfg_wr_o.addr), 64'(exp_addr[run][i]));
          check_value("cfg_wr_o.data", 64'(cfg_wr_o.data), 64'(exp_data[run][i]));
        end
        wait_cyc++;
        if (!took && wait_cyc > TIMEOUT_CYC)
        begin
          report_failure("configuration write request did not arrive in time");
          abort = 1'b1;
        end
      end
      delay    = {30'b0, rand_bit(), rand_bit()};   // 0..3 cycle response delay
      took     = 1'b0;
      wait_cyc = 0;
      exp_err  = exp_err || (resp_code[run][i] != RESP_OKAY);
      while (!took && !abort)
      begin
        @(negedge gtp_usr_clk);
        cfg_wr_ready_i   = 1'b0;
        cfg_resp_i       = resp_code[run][i];
        cfg_resp_valid_i = (delay == 0);
        if (delay > 0)
          delay--;
        #1;
        if (config_done_o)
          report_failure("config_done_o high before the last write response");
        took = cfg_resp_valid_i && cfg_resp_ready_o;
        wait_cyc++;
        if (!took && wait_cyc > TIMEOUT_CYC)
        begin
          report_failure("write response was not accepted in time");
          abort = 1'b1;
        end
      end
    end
    @(negedge gtp_usr_clk);
    cfg_resp_valid_i = 1'b0;
    #1;
    if (!abort)
    begin
      check_value("config_done_o", 64'(config_done_o), 64'(1'b1));   // one cycle after
      check_value("config_error_o", 64'(config_error_o), 64'(exp_err));
    end
  endtask

  // -------------------- byte source
  task automatic drive_bytes(input int run);
    int idx;
    int wait_cyc;
    idx      = 0;
    wait_cyc = 0;
    while (idx < byte_n[run] && !abort)
    begin
      @(negedge gtp_usr_clk);
      rx_valid_i = 1'b1;
      rx_byte_i  = in_bytes[run][idx];
      #1;
      if (rx_ready_o)
      begin
        idx++;                                 // taken at next rising edge
        wait_cyc = 0;
      end
      else
      begin
        wait_cyc++;
        if (wait_cyc > TIMEOUT_CYC)
        begin
          report_failure("rx_ready_o stayed low, byte stream stuck");
          abort = 1'b1;
        end
      end
    end
    @(negedge gtp_usr_clk);
    rx_valid_i = 1'b0;
  endtask

  // -------------------- word sink
  task automatic check_words(input int run);
    int   idx;
    int   wait_cyc;
    logic hold_low;
    idx      = 0;
    wait_cyc = 0;
    hold_low = (run == 0);                     // first run fills the fifo
    while (idx < word_n[run] && !abort)
    begin
      @(negedge gtp_usr_clk);
      if (hold_low && saw_full)
        hold_low = 1'b0;
      tx_ready_i = hold_low ? 1'b0 : rand_bit();
      #1;
      if (tx_valid_o && tx_ready_i)
      begin
        check_value("tx_word_o.data", 64'(tx_word_o.data), 64'(exp_words[run][idx].data));
        check_value("tx_word_o.keep", 64'(tx_word_o.keep), 64'(exp_words[run][idx].keep));
        check_value("tx_word_o.last", 64'(tx_word_o.last), 64'(exp_words[run][idx].last));
        idx++;
        wait_cyc = 0;
      end
      else
      begin
        wait_cyc++;
        if (wait_cyc > TIMEOUT_CYC)
        begin
          report_failure("expected word did not appear on tx_word_o in time");
          abort = 1'b1;
        end
      end
    end
  endtask

  // -------------------- stream monitor, just before each rising edge
  always @(negedge gtp_usr_clk)
  begin
    #1;
    if (monitor_en)
    begin
      if (tx_valid_o && !config_done_o)
        report_failure("tx_valid_o high before config_done_o");
      if (rx_valid_i && !rx_ready_o)
        saw_full = 1'b1;
      if (tx_valid_o && tx_ready_i)
        stall_bytes = 0;
      if (rx_valid_i && rx_ready_o)
        stall_bytes++;
      if (stall_bytes > FIFO_DEPTH + 3)
      begin
        report_failure("more bytes accepted than fifo, stage and output can hold");
        stall_bytes = 0;
      end
      if (word_held && (!tx_valid_o || tx_word_o !== held_word))
        report_failure("tx word or tx_valid_o changed before transfer");
      word_held = tx_valid_o && !tx_ready_i;
      held_word = tx_word_o;
    end
  end

  initial
  begin
    int run;
    int k;
    reset_i          = 1'b1;
    rx_byte_i        = '0;
    rx_valid_i       = 1'b0;
    tx_ready_i       = 1'b0;
    cfg_wr_ready_i   = 1'b0;
    cfg_resp_i       = '0;
    cfg_resp_valid_i = 1'b0;
    lfsr_q           = 32'he15c092b;
    mismatch_cnt     = 0;
    other_cnt        = 0;
    abort            = 1'b0;
    monitor_en       = 1'b0;
    saw_full         = 1'b0;
    stall_bytes      = 0;
    word_held        = 1'b0;
    held_word        = '0;
    load_patterns();
    for (run = 0; run < 2 && !abort; run++)
    begin
      monitor_en = 1'b0;
      apply_reset();
      saw_full    = 1'b0;
      stall_bytes = 0;
      word_held   = 1'b0;
      #1;
      check_value("rx_ready_o", 64'(rx_ready_o), 64'(1'b1));    // empty fifo
      check_value("cfg_wr_valid_o", 64'(cfg_wr_valid_o), 64'(1'b0));
      check_value("cfg_resp_ready_o", 64'(cfg_resp_ready_o), 64'(1'b0));
      check_value("tx_valid_o", 64'(tx_valid_o), 64'(1'b0));
      check_value("config_done_o", 64'(config_done_o), 64'(1'b0));
      check_value("config_error_o", 64'(config_error_o), 64'(1'b0));
      monitor_en = 1'b1;
      fork
        serve_config(run);
        drive_bytes(run);
        check_words(run);
      join
      if (!abort)
      begin
        if (run == 0 && !saw_full)
          report_failure("rx_ready_o never dropped while tx_ready_i was held low");
        for (k = 0; k < 4; k++)
        begin
          @(negedge gtp_usr_clk);
          tx_ready_i = 1'b1;
          #1;
          if (tx_valid_o)
            report_failure("extra word on tx_word_o after the last expected one");
        end
        check_value("config_done_o", 64'(config_done_o), 64'(1'b1));   // held
        check_value("cfg_wr_valid_o", 64'(cfg_wr_valid_o), 64'(1'b0));
      end
    end
    $display("errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/bridge_patterns.txt ====
# kind run f1 f2 f3, all hex. kind 1 = config write: addr data resp (0 okay, 2 slverr)
# kind 2 = input bytes: count data(first byte leftmost) last. kind 3 = word: data keep last
1 0 194 80000000 0
1 0 404 10000000 0
1 0 408 10000000 0
2 0 4 11223344 0
2 0 4 55667788 1
2 0 4 a1a2a3a4 0
2 0 1 a5 1
2 0 1 5c 1
2 0 4 d0d1d2d3 0
2 0 2 d4d5 1
2 0 3 e7e8e9 1
3 0 1122 3 0
3 0 3344 3 0
3 0 5566 3 0
3 0 7788 3 1
3 0 a1a2 3 0
3 0 a3a4 3 0
3 0 a500 2 1
3 0 5c00 2 1
3 0 d0d1 3 0
3 0 d2d3 3 0
3 0 d4d5 3 1
3 0 e7e8 3 0
3 0 e900 2 1
# second run, the receiver write is answered with slverr
1 1 194 80000000 0
1 1 404 10000000 2
1 1 408 10000000 0
2 1 4 0f1e2d3c 1
2 1 3 4b5a69 1
3 1 0f1e 3 0
3 1 2d3c 3 1
3 1 4b5a 3 0
3 1 6900 2 1

// ==== flist.f ====
verilog/eth_gtp_bridge_pkg.sv
verilog/reset_hold_timer.sv
verilog/mac_config_fsm.sv
verilog/rx_byte_fifo.sv
verilog/byte_to_word_packer.sv
verilog/eth_gtp_bridge_top.sv
verification/tb_eth_gtp_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f flist.f --top-module tb_eth_gtp_bridge -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# pass only when the testbench reported a clean run
echo "$out" | grep -q "^Finished with no errors$"
